//--- files.f
hdl/rvPkg.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/exeStage.sv
hdl/wbStage.sv
hdl/regFile.sv
hdl/execBackEnd.sv
test/execBackEndTb.sv

//--- hdl/alu.sv
`default_nettype none

module alu import rvPkg::*;
(
    input  aluOp_t          aluFn,
    input  logic [XLEN-1:0] opA,
    input  logic [XLEN-1:0] opB,
    input  logic            isBranch,
    input  logic            bNeq,
    output logic [XLEN-1:0] result,
    output logic            btaken
);

    logic [XLEN:0]   diff;      // one extra bit keeps the borrow
    logic            isEq;
    logic            isLtu;
    logic            isLt;
    logic [4:0]      shamt;
    logic            baseCond;

    // single subtractor shared by SUB, SLT/SLTU and the branch compares
    assign diff  = {1'b0, opA} - {1'b0, opB};
    assign isEq  = (diff[XLEN-1:0] == '0);
    assign isLtu = diff[XLEN];   // borrow out means opA < opB unsigned

    // signed less-than, sign bits decide when they differ
    assign isLt  = (opA[XLEN-1] != opB[XLEN-1]) ? opA[XLEN-1] : diff[XLEN-1];

    assign shamt = opB[4:0];

    always_comb
    begin
        unique case (aluFn)
            ADD:     result = opA + opB;
            SUB:     result = diff[XLEN-1:0];
            SLL:     result = opA << shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, isLt};
            SLTU:    result = {{(XLEN-1){1'b0}}, isLtu};
            XOR:     result = opA ^ opB;
            SRL:     result = opA >> shamt;
            SRA:     result = $signed(opA) >>> shamt;
            OR:      result = opA | opB;
            AND:     result = opA & opB;
            PASSB:   result = opB;
            default: result = '0;
        endcase
    end

    // base branch condition picked by the compare function
    always_comb
    begin
        case (aluFn)
            SUB:     baseCond = isEq;   // beq / bne
            SLT:     baseCond = isLt;   // blt / bge
            SLTU:    baseCond = isLtu;  // bltu / bgeu
            default: baseCond = 1'b0;
        endcase
    end

    assign btaken = isBranch & (baseCond ^ bNeq);

endmodule

`default_nettype wire

//--- hdl/branchUnit.sv
`default_nettype none

module branchUnit import rvPkg::*;
(
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] opA,
    input  logic [XLEN-1:0] opB,
    input  logic [XLEN-1:0] bImm,
    input  logic [XLEN-1:0] jImm,
    input  pcSel_t          pcSel,
    input  logic            jr,
    input  logic            btaken,
    output redirect_t       redirect
);

    logic [XLEN-1:0] branchTarget;
    logic [XLEN-1:0] jumpTarget;
    logic [XLEN-1:0] regTarget;

    assign branchTarget = pc + bImm;
    assign jumpTarget   = pc + jImm;
    assign regTarget    = (opA + opB) & ~{{(XLEN-1){1'b0}}, 1'b1};  // jalr clears bit 0

    always_comb
    begin
        if (jr)
            redirect.target = regTarget;
        else if (pcSel == JUMP)
            redirect.target = jumpTarget;
        else
            redirect.target = branchTarget;
    end

    // jumps always redirect, branches only when taken
    assign redirect.valid = (pcSel == JUMP) | ((pcSel == BRANCH) & btaken);

endmodule

`default_nettype wire

//--- hdl/exeStage.sv
`default_nettype none

module exeStage import rvPkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  issueOp_t   issueOp,
    output exeResult_t exeResult,
    output redirect_t  redirect
);

    issueOp_t        pipe5;     // operation in execute
    logic [XLEN-1:0] aluResult;
    logic            btaken;

    // pipe 5
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            pipe5 <= '0;
        end
        else
        begin
            pipe5 <= issueOp;
        end
    end

    alu exeAlu
    (
        .aluFn    (pipe5.aluFn),
        .opA      (pipe5.opA),
        .opB      (pipe5.opB),
        .isBranch (pipe5.pcSel == BRANCH),
        .bNeq     (pipe5.bNeq),
        .result   (aluResult),
        .btaken   (btaken)
    );

    branchUnit exeBranch
    (
        .pc       (pipe5.pc),
        .opA      (pipe5.opA),
        .opB      (pipe5.opB),
        .bImm     (pipe5.bImm),
        .jImm     (pipe5.jImm),
        .pcSel    (pipe5.pcSel),
        .jr       (pipe5.jr),
        .btaken   (btaken),
        .redirect (redirect)
    );

    // writeback still needs pc for the link address
    always_comb
    begin
        exeResult.we     = pipe5.we;
        exeResult.rd     = pipe5.rd;
        exeResult.link   = (pipe5.pcSel == JUMP);
        exeResult.result = aluResult;
        exeResult.pc     = pipe5.pc;
    end

endmodule

`default_nettype wire

//--- hdl/execBackEnd.sv
`default_nettype none

module execBackEnd import rvPkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  issueOp_t              issueOp,
    output redirect_t             redirect,
    input  logic [REG_ADDR_W-1:0] rdAddrA,
    input  logic [REG_ADDR_W-1:0] rdAddrB,
    output logic [XLEN-1:0]       rdDataA,
    output logic [XLEN-1:0]       rdDataB
);

    exeResult_t exeResult;  // pipe 5 to pipe 6
    regWrite_t  regWrite;   // pipe 6 to register file

    exeStage exeStage_inst
    (
        .clk       (clk),
        .nrst      (nrst),
        .issueOp   (issueOp),
        .exeResult (exeResult),
        .redirect  (redirect)
    );

    wbStage wbStage_inst
    (
        .clk       (clk),
        .nrst      (nrst),
        .exeResult (exeResult),
        .regWrite  (regWrite)
    );

    // read ports go back to the issue stage
    regFile regFile_inst
    (
        .clk      (clk),
        .nrst     (nrst),
        .regWrite (regWrite),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB)
    );

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`default_nettype none

module regFile import rvPkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  regWrite_t             regWrite,
    input  logic [REG_ADDR_W-1:0] rdAddrA,
    input  logic [REG_ADDR_W-1:0] rdAddrB,
    output logic [XLEN-1:0]       rdDataA,
    output logic [XLEN-1:0]       rdDataB
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 1; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (regWrite.en && (regWrite.addr != '0))
        begin
            regs[regWrite.addr] <= regWrite.data;
        end
    end

    // asynchronous read, x0 always zero
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

//--- hdl/rvPkg.sv
`default_nettype none

package rvPkg;

    // RV32I base widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    // ALU functions
    // SUB, SLT and SLTU double as the compare for beq/bne, blt/bge and bltu/bgeu
    typedef enum logic [3:0]
    {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        PASSB = 4'd10  // lui
    } aluOp_t;

    // next-pc selection
    typedef enum logic [1:0]
    {
        SEQ    = 2'd0,  // pc + 4
        BRANCH = 2'd1,  // conditional, pc + bImm
        JUMP   = 2'd2   // jal or jalr
    } pcSel_t;

    // decoded operation handed over by the issue stage
    typedef struct packed
    {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        aluOp_t                aluFn;
        logic                  bNeq;   // invert the branch condition
        logic [XLEN-1:0]       opA;
        logic [XLEN-1:0]       opB;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       bImm;
        logic [XLEN-1:0]       jImm;
        pcSel_t                pcSel;
        logic                  jr;     // jalr, target from opA + opB
    } issueOp_t;

    // execute to writeback
    typedef struct packed
    {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic                  link;   // write pc + 4 instead of result
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       pc;
    } exeResult_t;

    // next-pc request back to fetch
    typedef struct packed
    {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    // register file write port
    typedef struct packed
    {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } regWrite_t;

endpackage

`default_nettype wire

//--- hdl/wbStage.sv
`default_nettype none

module wbStage import rvPkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  exeResult_t exeResult,
    output regWrite_t  regWrite
);

    exeResult_t      pipe6;     // operation in writeback
    logic [XLEN-1:0] linkAddr;

    // pipe 6
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            pipe6 <= '0;
        end
        else
        begin
            pipe6 <= exeResult;
        end
    end

    // return address for jal / jalr
    assign linkAddr = pipe6.pc + XLEN'(4);

    always_comb
    begin
        regWrite.en   = pipe6.we;
        regWrite.addr = pipe6.rd;
        regWrite.data = pipe6.link ? linkAddr : pipe6.result;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the execBackEnd testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module execBackEndTb -f files.f \
    --Mdir obj_dir -o simv

# the testbench decides, the log is searched afterwards
./obj_dir/simv 2>&1 | tee "$LOG"

if grep -q "^All checks passed$" "$LOG"; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED, see $LOG"
    exit 1
fi

//--- test/execBackEndTb.sv
`default_nettype none

module execBackEndTb import rvPkg::*;
();

    localparam int          RESET_CYCLES  = 10;
    localparam int          RESET_TIMEOUT = 50;
    localparam int          NUM_RANDOM    = 9;
    localparam logic [31:0] ALU_PC        = 32'h0000_1000;
    localparam logic [32:0] ALU_REDIR     = {1'b0, ALU_PC};  // SEQ with bImm 0 targets pc
    localparam logic [31:0] BR_PC         = 32'h0000_2000;
    localparam logic [31:0] B_OFF         = 32'h0000_0040;
    localparam logic [31:0] B_TGT         = 32'h0000_2040;

    // one table row
    typedef struct packed
    {
        issueOp_t    op;
        logic [31:0] expReg;
        redirect_t   expRedir;
    } testVec_t;

    logic            clk;
    logic            nrst;
    issueOp_t        issueOp;
    redirect_t       redirect;
    logic [4:0]      rdAddrA;
    logic [4:0]      rdAddrB;
    logic [31:0]     rdDataA;
    logic [31:0]     rdDataB;

    testVec_t        vecs[$];
    string           names[$];
    int              schedule[$];   // table index per cycle, -1 is a bubble
    int              seed;

    execBackEnd execBackEnd_inst
    (
        .clk      (clk),
        .nrst     (nrst),
        .issueOp  (issueOp),
        .redirect (redirect),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial
    begin
        nrst <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
    end

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %0h, actual %0h", testName, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch in %s", testName);
        end
    endtask

    function automatic issueOp_t aluOp(input logic [4:0] rd, input aluOp_t fn,
                                       input logic [31:0] a, input logic [31:0] b);
        issueOp_t op;
        op       = '0;
        op.we    = 1'b1;
        op.rd    = rd;
        op.aluFn = fn;
        op.opA   = a;
        op.opB   = b;
        op.pc    = ALU_PC;
        op.pcSel = SEQ;
        return op;
    endfunction

    // branches write nothing, rd stays x0
    function automatic issueOp_t branchOp(input aluOp_t fn, input logic bNeq,
                                          input logic [31:0] a, input logic [31:0] b,
                                          input logic [31:0] bImm);
        issueOp_t op;
        op       = '0;
        op.aluFn = fn;
        op.bNeq  = bNeq;
        op.opA   = a;
        op.opB   = b;
        op.pc    = BR_PC;
        op.bImm  = bImm;
        op.pcSel = BRANCH;
        return op;
    endfunction

    function automatic issueOp_t jumpOp(input logic [4:0] rd, input logic [31:0] pc,
                                        input logic [31:0] jImm, input logic [31:0] a,
                                        input logic [31:0] b, input logic jr);
        issueOp_t op;
        op       = '0;
        op.we    = 1'b1;
        op.rd    = rd;
        op.aluFn = ADD;
        op.opA   = a;
        op.opB   = b;
        op.pc    = pc;
        op.jImm  = jImm;
        op.pcSel = JUMP;
        op.jr    = jr;
        return op;
    endfunction

    task automatic addEntry(input string name, input issueOp_t op, input logic [31:0] expReg,
                            input redirect_t expRedir);
        testVec_t vec;
        vec.op       = op;
        vec.expReg   = expReg;
        vec.expRedir = expRedir;
        vecs.push_back(vec);
        names.push_back(name);
    endtask

    task automatic buildTable();
        issueOp_t    tmpOp;
        aluOp_t      fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        string       label;
        addEntry("add", aluOp(5'd1, ADD, 32'h0000_1234, 32'h0000_4321), 32'h0000_5555, ALU_REDIR);
        addEntry("sub", aluOp(5'd2, SUB, 32'd5, 32'd7), 32'hFFFF_FFFE, ALU_REDIR);
        addEntry("sll", aluOp(5'd3, SLL, 32'd1, 32'h0000_0025), 32'h0000_0020, ALU_REDIR);
        addEntry("slt_neg", aluOp(5'd4, SLT, 32'hFFFF_FFFF, 32'd1), 32'd1, ALU_REDIR);
        addEntry("sltu_neg", aluOp(5'd5, SLTU, 32'hFFFF_FFFF, 32'd1), 32'd0, ALU_REDIR);
        addEntry("xor", aluOp(5'd6, XOR, 32'hF0F0_F0F0, 32'hFF00_FF00), 32'h0FF0_0FF0, ALU_REDIR);
        addEntry("srl", aluOp(5'd7, SRL, 32'h8000_0000, 32'd4), 32'h0800_0000, ALU_REDIR);
        addEntry("sra_neg", aluOp(5'd8, SRA, 32'h8000_0000, 32'd4), 32'hF800_0000, ALU_REDIR);
        addEntry("or", aluOp(5'd9, OR, 32'h1200_0034, 32'h0056_7800), 32'h1256_7834, ALU_REDIR);
        addEntry("and", aluOp(5'd10, AND, 32'hFFFF_0000, 32'h1234_5678), 32'h1234_0000,
                 ALU_REDIR);
        addEntry("lui", aluOp(5'd11, PASSB, 32'd0, 32'hABCD_E000), 32'hABCD_E000, ALU_REDIR);
        addEntry("x0_write", aluOp(5'd0, ADD, 32'd1, 32'd2), 32'd0, ALU_REDIR);
        tmpOp    = aluOp(5'd1, ADD, 32'd7, 32'd8);
        tmpOp.we = 1'b0;
        addEntry("we_low", tmpOp, 32'h0000_5555, ALU_REDIR);  // x1 keeps the add result

        // taken and not-taken pairs for every branch flavour
        addEntry("beq_taken", branchOp(SUB, 1'b0, 32'd5, 32'd5, B_OFF), 32'd0, {1'b1, B_TGT});
        addEntry("beq_not", branchOp(SUB, 1'b0, 32'd5, 32'd6, B_OFF), 32'd0, {1'b0, B_TGT});
        addEntry("bne_taken", branchOp(SUB, 1'b1, 32'd5, 32'd6, 32'hFFFF_FFF0), 32'd0,
                 {1'b1, 32'h0000_1FF0});
        addEntry("bne_not", branchOp(SUB, 1'b1, 32'd5, 32'd5, B_OFF), 32'd0, {1'b0, B_TGT});
        addEntry("blt_taken", branchOp(SLT, 1'b0, 32'hFFFF_FFFE, 32'd3, B_OFF), 32'd0,
                 {1'b1, B_TGT});
        addEntry("blt_not", branchOp(SLT, 1'b0, 32'd3, 32'hFFFF_FFFE, B_OFF), 32'd0,
                 {1'b0, B_TGT});
        addEntry("bge_taken", branchOp(SLT, 1'b1, 32'd3, 32'hFFFF_FFFE, B_OFF), 32'd0,
                 {1'b1, B_TGT});
        addEntry("bge_not", branchOp(SLT, 1'b1, 32'hFFFF_FFFE, 32'd3, B_OFF), 32'd0,
                 {1'b0, B_TGT});
        addEntry("bltu_taken", branchOp(SLTU, 1'b0, 32'd3, 32'hFFFF_FFFE, B_OFF), 32'd0,
                 {1'b1, B_TGT});
        addEntry("bltu_not", branchOp(SLTU, 1'b0, 32'hFFFF_FFFE, 32'd3, B_OFF), 32'd0,
                 {1'b0, B_TGT});
        addEntry("bgeu_taken", branchOp(SLTU, 1'b1, 32'hFFFF_FFFE, 32'd3, B_OFF), 32'd0,
                 {1'b1, B_TGT});
        addEntry("bgeu_not", branchOp(SLTU, 1'b1, 32'd3, 32'hFFFF_FFFE, B_OFF), 32'd0,
                 {1'b0, B_TGT});

        addEntry("jal", jumpOp(5'd12, 32'h3000, 32'h800, 32'd0, 32'd0, 1'b0), 32'h0000_3004,
                 {1'b1, 32'h0000_3800});
        addEntry("jalr", jumpOp(5'd13, 32'h3100, 32'h800, 32'h4001, 32'h10, 1'b1),
                 32'h0000_3104, {1'b1, 32'h0000_4010});  // bit 0 of 4011 dropped

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            case (i % 3)
                0:
                begin
                    fn       = ADD;
                    expected = a + b;
                    label    = "rand_add";
                end
                1:
                begin
                    fn       = XOR;
                    expected = a ^ b;
                    label    = "rand_xor";
                end
                default:
                begin
                    fn       = SLTU;
                    expected = {31'b0, a < b};
                    label    = "rand_sltu";
                end
            endcase
            addEntry($sformatf("%s_%0d", label, i), aluOp(5'(14 + i), fn, a, b), expected,
                     ALU_REDIR);
        end
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (nrst !== 1'b1)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT)
            begin
                $display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
                $display("Checks failed");
                $fatal(1, "timeout waiting for the end of reset");
            end
        end
    endtask

    task automatic checkResetState();
        for (int i = 0; i < 32; i++)
        begin
            @(posedge clk);
            rdAddrA <= 5'(i);
            rdAddrB <= 5'(i);
            @(negedge clk);
            checkValue($sformatf("reset_x%0d_portA", i), 64'd0, 64'(rdDataA));
            checkValue($sformatf("reset_x%0d_portB", i), 64'd0, 64'(rdDataB));
            checkValue("reset_redirect", 64'd0, 64'(redirect.valid));
        end
    endtask

    // overwrite x1..x31 with a per-register pattern, then drain the pipe
    task automatic fillRegisters();
        issueOp_t op;
        for (int r = 1; r < 32; r++)
        begin
            op = aluOp(5'(r), PASSB, 32'd0, 32'hA5A5_0000 | 32'(r));
            @(posedge clk);
            issueOp <= op;
        end
        repeat (3)
        begin
            @(posedge clk);
            issueOp <= '0;
        end
    endtask

    // redirect of slot t-1 is live now, the write of slot t-3 landed on this edge
    task automatic runSchedule(input string passName);
        int cur;
        int prev;
        int old;
        for (int t = 0; t < schedule.size() + 3; t++)
        begin
            cur  = (t < schedule.size()) ? schedule[t] : -1;
            prev = (t >= 1 && t - 1 < schedule.size()) ? schedule[t-1] : -1;
            old  = (t >= 3) ? schedule[t-3] : -1;
            @(posedge clk);
            if (cur >= 0)
                issueOp <= vecs[cur].op;
            else
                issueOp <= '0;
            if (old >= 0)
            begin
                rdAddrA <= vecs[old].op.rd;
                rdAddrB <= vecs[old].op.rd;
            end
            @(negedge clk);
            if (prev >= 0)
                checkValue({passName, ":", names[prev], ":redirect"},
                           64'(vecs[prev].expRedir), 64'(redirect));
            else
                checkValue({passName, ":bubble:redirect"}, 64'd0, 64'(redirect));
            if (old >= 0)
            begin
                checkValue({passName, ":", names[old], ":regA"}, 64'(vecs[old].expReg),
                           64'(rdDataA));
                checkValue({passName, ":", names[old], ":regB"}, 64'(vecs[old].expReg),
                           64'(rdDataB));
            end
        end
    endtask

    initial
    begin
        issueOp <= '0;
        rdAddrA <= '0;
        rdAddrB <= '0;
        seed = 32'h7fbf;
        buildTable();
        waitForReset();
        checkResetState();

        // each operation followed by a bubble
        schedule.delete();
        foreach (vecs[i])
        begin
            schedule.push_back(i);
            schedule.push_back(-1);
        end
        runSchedule("spaced");

        fillRegisters();

        schedule.delete();
        foreach (vecs[i])
        begin
            schedule.push_back(i);  // back to back
        end
        runSchedule("streamed");

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
